// File: run.sh
#!/bin/sh
# build with Verilator, run, then judge the log
verilator --binary --timing --assert -Wno-fatal --top-module mist_base_tb \
   -f src.f -o mist_base_sim || exit 1
./obj_dir/mist_base_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0

// File: src.f
src/mist_pkg.sv
src/spi_byte_rx.sv
src/spi_user_io.sv
src/spi_data_io.sv
src/osd_overlay.sv
src/rgb2ypbpr.sv
src/sigma_delta_dac.sv
src/mist_base.sv
tests/mist_base_sva.sv
tests/mist_base_tb.sv

// File: src/mist_base.sv
// MiST platform top: SPI receivers, command decoders, video chain and sound DAC
`default_nettype none

module mist_base import mist_pkg::*; (
   input  wire         clk_sys,
   input  wire         reset_i,
   // SPI from the board controller
   input  wire         spi_sck_i,
   input  wire         spi_di_i,
   input  wire         spi_ss2_i,
   input  wire         spi_ss3_i,
   input  wire         conf_data0_i,
   // native game video
   input  game_color_t game_r_i,
   input  game_color_t game_g_i,
   input  game_color_t game_b_i,
   input  wire         lhbl_i,
   input  wire         lvbl_i,
   input  wire         hs_i,
   input  wire         vs_i,
   // scan doubled video
   input  color_t      vga_r_i,
   input  color_t      vga_g_i,
   input  color_t      vga_b_i,
   input  wire         vga_hsync_i,
   input  wire         vga_vsync_i,
   input  pcm_t        snd_i,
   output color_t      video_r_o,
   output color_t      video_g_o,
   output color_t      video_b_o,
   output logic        video_hs_o,
   output logic        video_vs_o,
   output logic        osd_shown_o,
   output word_t       status_o,
   output word_t       joystick1_o,
   output word_t       joystick2_o,
   output ioaddr_t     ioctl_addr_o,
   output byte_t       ioctl_data_o,
   output logic        ioctl_wr_o,
   output logic        downloading_o,
   output logic        snd_pwm_o
);

   byte_t  io_byte, dl_byte, osd_byte;
   logic   io_valid, dl_valid, osd_valid;
   logic   io_first, dl_first, osd_first;
   color_t osd_r, osd_g, osd_b;
   logic   osd_hs, osd_vs;

   // one receiver per chip select on the shared SCK/SDI
   spi_byte_rx io_rx_inst (
      .clk_sys, .reset_i,
      .sck_i(spi_sck_i), .ss_n_i(conf_data0_i), .sdi_i(spi_di_i),
      .byte_o(io_byte), .byte_valid_o(io_valid), .first_o(io_first)
   );

   spi_byte_rx dl_rx_inst (
      .clk_sys, .reset_i,
      .sck_i(spi_sck_i), .ss_n_i(spi_ss2_i), .sdi_i(spi_di_i),
      .byte_o(dl_byte), .byte_valid_o(dl_valid), .first_o(dl_first)
   );

   spi_byte_rx osd_rx_inst (
      .clk_sys, .reset_i,
      .sck_i(spi_sck_i), .ss_n_i(spi_ss3_i), .sdi_i(spi_di_i),
      .byte_o(osd_byte), .byte_valid_o(osd_valid), .first_o(osd_first)
   );

   spi_user_io user_io_inst (
      .clk_sys, .reset_i,
      .byte_i(io_byte), .byte_valid_i(io_valid), .first_i(io_first),
      .status_o, .joystick1_o, .joystick2_o
   );

   spi_data_io data_io_inst (
      .clk_sys, .reset_i,
      .byte_i(dl_byte), .byte_valid_i(dl_valid), .first_i(dl_first),
      .ioctl_addr_o, .ioctl_data_o, .ioctl_wr_o, .downloading_o
   );

   osd_overlay osd_inst (
      .clk_sys, .reset_i,
      .byte_i(osd_byte), .byte_valid_i(osd_valid), .first_i(osd_first),
      .sd_disable_i(status_o[STATUS_SD_DIS]),
      .game_r_i, .game_g_i, .game_b_i,
      .vga_r_i, .vga_g_i, .vga_b_i,
      .hs_i, .vs_i, .vga_hsync_i, .vga_vsync_i, .lhbl_i, .lvbl_i,
      .r_o(osd_r), .g_o(osd_g), .b_o(osd_b),
      .hsync_o(osd_hs), .vsync_o(osd_vs), .osd_shown_o
   );

   // composite sync for native video or YPbPr
   rgb2ypbpr ypbpr_inst (
      .clk_sys, .reset_i,
      .r_i(osd_r), .g_i(osd_g), .b_i(osd_b),
      .hsync_i(osd_hs), .vsync_i(osd_vs),
      .ypbpr_i(status_o[STATUS_YPBPR]),
      .csync_en_i(status_o[STATUS_SD_DIS] | status_o[STATUS_YPBPR]),
      .video_r_o, .video_g_o, .video_b_o, .video_hs_o, .video_vs_o
   );

   sigma_delta_dac dac_inst (
      .clk_sys, .reset_i, .snd_i, .snd_pwm_o
   );

endmodule

`default_nettype wire

// File: src/mist_pkg.sv
// shared types, SPI command codes, OSD geometry, YPbPr and sound constants
`default_nettype none

package mist_pkg;

   // vector types
   typedef logic [7:0]  byte_t;
   typedef logic [31:0] word_t;
   typedef logic [21:0] ioaddr_t;
   typedef logic [5:0]  color_t;
   typedef logic [3:0]  game_color_t;
   typedef logic [15:0] pcm_t;

   // user io commands on conf_data0
   localparam byte_t CMD_STATUS   = 8'h1e;
   localparam byte_t CMD_JOY1     = 8'h01;
   localparam byte_t CMD_JOY2     = 8'h02;

   // ROM download commands on ss2
   localparam byte_t CMD_DL_START = 8'h54;
   localparam byte_t CMD_DL_END   = 8'h55;
   localparam byte_t CMD_DL_DATA  = 8'h56;

   // OSD commands on ss3
   localparam byte_t CMD_OSD_ON   = 8'h41;
   localparam byte_t CMD_OSD_OFF  = 8'h40;

   // OSD window in pixels and lines
   localparam logic [7:0] OSD_X0 = 8'd16;
   localparam logic [7:0] OSD_W  = 8'd32;
   localparam logic [7:0] OSD_Y0 = 8'd4;
   localparam logic [7:0] OSD_H  = 8'd8;

   // bit positions inside the status word
   localparam int STATUS_YPBPR  = 5;
   localparam int STATUS_SD_DIS = 6;

   // luma weights, scaled by 2^Y_SHIFT
   localparam logic [5:0] Y_KR    = 6'd19;
   localparam logic [5:0] Y_KG    = 6'd38;
   localparam logic [5:0] Y_KB    = 6'd7;
   localparam int         Y_SHIFT = 6;

   // game sound is two's complement
   localparam logic SND_SIGNED = 1'b1;

   typedef enum logic {OSD_HIDDEN, OSD_SHOWN} osd_state_e;
   typedef enum logic [1:0] {DL_CMD, DL_DATA, DL_IGNORE} dl_state_e;

endpackage

`default_nettype wire

// File: src/osd_overlay.sv
// video source select, OSD show register, beam counters and window tint
`default_nettype none

module osd_overlay import mist_pkg::*; (
   input  wire         clk_sys,
   input  wire         reset_i,
   input  byte_t       byte_i,
   input  wire         byte_valid_i,
   input  wire         first_i,
   input  wire         sd_disable_i,
   input  game_color_t game_r_i,
   input  game_color_t game_g_i,
   input  game_color_t game_b_i,
   input  color_t      vga_r_i,
   input  color_t      vga_g_i,
   input  color_t      vga_b_i,
   input  wire         hs_i,
   input  wire         vs_i,
   input  wire         vga_hsync_i,
   input  wire         vga_vsync_i,
   input  wire         lhbl_i,
   input  wire         lvbl_i,
   output color_t      r_o,
   output color_t      g_o,
   output color_t      b_o,
   output logic        hsync_o,
   output logic        vsync_o,
   output logic        osd_shown_o
);

   osd_state_e state;
   logic [9:0] hcount;
   logic [9:0] vcount;
   logic       lhbl_d;
   logic       in_win;
   logic       tint;
   color_t     src_r;
   color_t     src_g;
   color_t     src_b;
   logic       src_hs;
   logic       src_vs;

   assign osd_shown_o = (state == OSD_SHOWN);

   // native video is widened by repeating its top bits
   assign src_r  = sd_disable_i ? {game_r_i, game_r_i[3:2]} : vga_r_i;
   assign src_g  = sd_disable_i ? {game_g_i, game_g_i[3:2]} : vga_g_i;
   assign src_b  = sd_disable_i ? {game_b_i, game_b_i[3:2]} : vga_b_i;
   assign src_hs = sd_disable_i ? ~hs_i : vga_hsync_i;
   assign src_vs = sd_disable_i ? ~vs_i : vga_vsync_i;

   assign in_win = (hcount >= OSD_X0) && (hcount < OSD_X0 + OSD_W) &&
                   (vcount >= OSD_Y0) && (vcount < OSD_Y0 + OSD_H);
   assign tint   = osd_shown_o && in_win;

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         state  <= OSD_HIDDEN;
         hcount <= '0;
         vcount <= '0;
         lhbl_d <= 1'b0;
      end else begin
         lhbl_d <= lhbl_i;
         if (byte_valid_i && first_i) begin
            if (byte_i == CMD_OSD_ON)
               state <= OSD_SHOWN;
            else if (byte_i == CMD_OSD_OFF)
               state <= OSD_HIDDEN;
         end
         if (!lhbl_i)
            hcount <= '0;
         else
            hcount <= hcount + 10'd1;
         // one line per end of active video
         if (!lvbl_i)
            vcount <= '0;
         else if (lhbl_d && !lhbl_i)
            vcount <= vcount + 10'd1;
      end
   end

   // halve the picture under the window, blue gets lifted
   always_ff @(posedge clk_sys) begin
      r_o     <= tint ? {1'b0, src_r[5:1]} : src_r;
      g_o     <= tint ? {1'b0, src_g[5:1]} : src_g;
      b_o     <= tint ? {1'b1, src_b[5:1]} : src_b;
      hsync_o <= src_hs;
      vsync_o <= src_vs;
   end

endmodule

`default_nettype wire

// File: src/rgb2ypbpr.sv
// RGB to YPbPr conversion, output select and composite sync
`default_nettype none

module rgb2ypbpr import mist_pkg::*; (
   input  wire    clk_sys,
   input  wire    reset_i,
   input  color_t r_i,
   input  color_t g_i,
   input  color_t b_i,
   input  wire    hsync_i,
   input  wire    vsync_i,
   input  wire    ypbpr_i,
   input  wire    csync_en_i,
   output color_t video_r_o,
   output color_t video_g_o,
   output color_t video_b_o,
   output logic   video_hs_o,
   output logic   video_vs_o
);

   logic [11:0]       y_sum;
   color_t            y;
   logic signed [7:0] pb_diff;
   logic signed [7:0] pr_diff;
   logic signed [8:0] pb_sum;
   logic signed [8:0] pr_sum;

   function automatic color_t clamp6(input logic signed [8:0] v);
      if (v < 0)
         return '0;
      else if (v > 9'sd63)
         return 6'd63;
      else
         return v[5:0];
   endfunction

   always_comb begin
      y_sum   = Y_KR * r_i + Y_KG * g_i + Y_KB * b_i;
      y       = color_t'(y_sum >> Y_SHIFT);
      pb_diff = $signed({2'b00, b_i}) - $signed({2'b00, y});
      pr_diff = $signed({2'b00, r_i}) - $signed({2'b00, y});
      // signed division rounds toward zero
      pb_sum  = 9'sd32 + pb_diff / 8'sd2;
      pr_sum  = 9'sd32 + pr_diff / 8'sd2;
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         video_r_o <= '0;
         video_g_o <= '0;
         video_b_o <= '0;
      end else begin
         video_r_o <= ypbpr_i ? clamp6(pr_sum) : r_i;
         video_g_o <= ypbpr_i ? y : g_i;
         video_b_o <= ypbpr_i ? clamp6(pb_sum) : b_i;
      end
   end

   // a scart cable wants csync on hs and a high vs for RGB mode
   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         video_hs_o <= 1'b0;
         video_vs_o <= 1'b0;
      end else if (csync_en_i) begin
         video_hs_o <= ~(hsync_i ^ vsync_i);
         video_vs_o <= 1'b1;
      end else begin
         video_hs_o <= hsync_i;
         video_vs_o <= vsync_i;
      end
   end

endmodule

`default_nettype wire

// File: src/sigma_delta_dac.sv
// first-order 1-bit sigma-delta sound DAC
`default_nettype none

module sigma_delta_dac import mist_pkg::*; (
   input  wire  clk_sys,
   input  wire  reset_i,
   input  pcm_t snd_i,
   output logic snd_pwm_o
);

   pcm_t        sample;
   pcm_t        acc;
   logic [16:0] sum;

   // offset binary for the accumulator
   assign sample = {snd_i[15] ^ SND_SIGNED, snd_i[14:0]};
   assign sum    = {1'b0, acc} + {1'b0, sample};

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         acc       <= '0;
         snd_pwm_o <= 1'b0;
      end else begin
         acc       <= sum[15:0];
         // carry density tracks the sample value
         snd_pwm_o <= sum[16];
      end
   end

endmodule

`default_nettype wire

// File: src/spi_byte_rx.sv
// SPI mode-0 slave byte receiver, oversampled in the system clock
`default_nettype none

module spi_byte_rx import mist_pkg::*; (
   input  wire   clk_sys,
   input  wire   reset_i,
   input  wire   sck_i,
   input  wire   ss_n_i,
   input  wire   sdi_i,
   output byte_t byte_o,
   output logic  byte_valid_o,
   output logic  first_o
);

   // two sync stages, sck has a third for edge detection
   logic [2:0] sck_sync;
   logic [1:0] ss_sync;
   logic [1:0] sdi_sync;
   logic       sck_rise;
   logic [2:0] bit_cnt;
   logic [6:0] shift;
   logic       first_pend;

   assign sck_rise = sck_sync[1] & ~sck_sync[2];

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         sck_sync     <= '0;
         ss_sync      <= '1;
         sdi_sync     <= '0;
         bit_cnt      <= '0;
         first_pend   <= 1'b1;
         byte_valid_o <= 1'b0;
         first_o      <= 1'b0;
      end else begin
         sck_sync     <= {sck_sync[1:0], sck_i};
         ss_sync      <= {ss_sync[0], ss_n_i};
         sdi_sync     <= {sdi_sync[0], sdi_i};
         byte_valid_o <= 1'b0;
         if (ss_sync[1]) begin
            // deselected, next byte starts a new transfer
            bit_cnt    <= '0;
            first_pend <= 1'b1;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               byte_valid_o <= 1'b1;
               first_o      <= first_pend;
               first_pend   <= 1'b0;
            end
         end
      end
   end

   // data path, MSB first
   always_ff @(posedge clk_sys) begin
      if (!ss_sync[1] && sck_rise) begin
         shift <= {shift[5:0], sdi_sync[1]};
         if (bit_cnt == 3'd7)
            byte_o <= {shift, sdi_sync[1]};
      end
   end

endmodule

`default_nettype wire

// File: src/spi_data_io.sv
// ROM download decoder producing ioctl writes
`default_nettype none

module spi_data_io import mist_pkg::*; (
   input  wire     clk_sys,
   input  wire     reset_i,
   input  byte_t   byte_i,
   input  wire     byte_valid_i,
   input  wire     first_i,
   output ioaddr_t ioctl_addr_o,
   output byte_t   ioctl_data_o,
   output logic    ioctl_wr_o,
   output logic    downloading_o
);

   dl_state_e state;
   logic      data_byte;

   // a byte following CMD_DL_DATA in the same selection
   assign data_byte = byte_valid_i && !first_i && (state == DL_DATA);

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         state         <= DL_CMD;
         downloading_o <= 1'b0;
         ioctl_wr_o    <= 1'b0;
         ioctl_addr_o  <= '0;
      end else begin
         ioctl_wr_o <= data_byte && downloading_o;
         // address moves on once the write has been seen
         if (ioctl_wr_o)
            ioctl_addr_o <= ioctl_addr_o + 22'd1;
         if (byte_valid_i && first_i) begin
            case (byte_i)
               CMD_DL_START: begin
                  downloading_o <= 1'b1;
                  ioctl_addr_o  <= '0;
                  state         <= DL_IGNORE;
               end
               CMD_DL_END: begin
                  downloading_o <= 1'b0;
                  state         <= DL_IGNORE;
               end
               CMD_DL_DATA: state <= DL_DATA;
               default:     state <= DL_IGNORE;
            endcase
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (data_byte)
         ioctl_data_o <= byte_i;
   end

endmodule

`default_nettype wire

// File: src/spi_user_io.sv
// user io command decoder for the status and joystick words
`default_nettype none

module spi_user_io import mist_pkg::*; (
   input  wire   clk_sys,
   input  wire   reset_i,
   input  byte_t byte_i,
   input  wire   byte_valid_i,
   input  wire   first_i,
   output word_t status_o,
   output word_t joystick1_o,
   output word_t joystick2_o
);

   byte_t       cmd;
   logic [2:0]  byte_cnt;
   logic [23:0] shadow;
   logic        data_byte;

   // payload byte of the current command, up to four of them
   assign data_byte = byte_valid_i && !first_i && (byte_cnt != 3'd4);

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         cmd         <= '0;
         byte_cnt    <= '0;
         status_o    <= '0;
         joystick1_o <= '0;
         joystick2_o <= '0;
      end else if (byte_valid_i && first_i) begin
         cmd      <= byte_i;
         byte_cnt <= '0;
      end else if (data_byte) begin
         byte_cnt <= byte_cnt + 3'd1;
         // fourth byte commits the word
         if (byte_cnt == 3'd3) begin
            case (cmd)
               CMD_STATUS: status_o    <= {shadow, byte_i};
               CMD_JOY1:   joystick1_o <= {shadow, byte_i};
               CMD_JOY2:   joystick2_o <= {shadow, byte_i};
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (data_byte)
         shadow <= {shadow[15:0], byte_i};
   end

endmodule

`default_nettype wire

// File: tests/mist_base_sva.sv
// concurrent assertions on the ioctl strobe, composite sync and output levels after reset
`default_nettype none

module mist_base_sva import mist_pkg::*; (
   input wire        clk_sys,
   input wire        reset_i,
   input wire [31:0] status_o,
   input wire [31:0] joystick1_o,
   input wire [31:0] joystick2_o,
   input wire [5:0]  video_r_o,
   input wire [5:0]  video_g_o,
   input wire [5:0]  video_b_o,
   input wire        video_hs_o,
   input wire        video_vs_o,
   input wire        osd_shown_o,
   input wire [21:0] ioctl_addr_o,
   input wire        ioctl_wr_o,
   input wire        downloading_o,
   input wire        snd_pwm_o
);

   // a write belongs to an open download and lasts one cycle
   wr_in_download: assert property (@(posedge clk_sys) disable iff (reset_i)
      ioctl_wr_o |-> downloading_o)
      else $error("ioctl_wr_o high while no download is open");

   wr_single: assert property (@(posedge clk_sys) disable iff (reset_i)
      ioctl_wr_o |=> !ioctl_wr_o)
      else $error("ioctl_wr_o high for two cycles in a row");

   // composite sync parks vs high
   csync_vs_high: assert property (@(posedge clk_sys) disable iff (reset_i)
      (status_o[STATUS_SD_DIS] || status_o[STATUS_YPBPR]) |=> video_vs_o)
      else $error("video_vs_o low with composite sync selected");

   outputs_known: assert property (@(posedge clk_sys) disable iff (reset_i)
      !$isunknown({video_r_o, video_g_o, video_b_o, video_hs_o, video_vs_o, osd_shown_o,
                   status_o, joystick1_o, joystick2_o, ioctl_addr_o, ioctl_wr_o,
                   downloading_o, snd_pwm_o}))
      else $error("an output is unknown after reset");

endmodule

bind mist_base mist_base_sva sva_inst (.*);

`default_nettype wire

// File: tests/mist_base_tb.sv
// testbench for mist_base with LFSR stimulus, SPI driver tasks, reference model and watchdog
`default_nettype none

module mist_base_tb;

   // command bytes as sent by the board controller
   localparam logic [7:0] OP_STATUS   = 8'h1e;
   localparam logic [7:0] OP_JOY1     = 8'h01;
   localparam logic [7:0] OP_JOY2     = 8'h02;
   localparam logic [7:0] OP_DL_START = 8'h54;
   localparam logic [7:0] OP_DL_END   = 8'h55;
   localparam logic [7:0] OP_DL_DATA  = 8'h56;
   localparam logic [7:0] OP_OSD_ON   = 8'h41;
   localparam logic [7:0] OP_OSD_OFF  = 8'h40;

   // OSD window and status bit positions
   localparam int WIN_X0     = 16;
   localparam int WIN_W      = 32;
   localparam int WIN_Y0     = 4;
   localparam int WIN_H      = 8;
   localparam int BIT_YPBPR  = 5;
   localparam int BIT_SD_DIS = 6;

   // raster for the video runs
   localparam int LINE_LEN    = 64;
   localparam int LINE_ACT    = 56;
   localparam int FRAME_LINES = 16;
   localparam int FRAME_ACT   = 14;
   localparam int VID_LEN     = LINE_LEN * FRAME_LINES;

   localparam int CLK_PERIOD = 40;
   localparam int PHASE      = 4;
   localparam int BYTE_CYC   = 16 * PHASE;
   localparam int XFER_OVH   = 16;
   localparam int DL_N       = 12;
   localparam int SND_RUNS   = 6;
   localparam int TEST_CYCLES = 8 + 3 * (6 * BYTE_CYC + XFER_OVH)
                              + 3 * XFER_OVH + (DL_N + 3) * BYTE_CYC
                              + 8 * (2 * XFER_OVH + 6 * BYTE_CYC + VID_LEN + 2)
                              + SND_RUNS * (2 + 512);

   logic        clk_sys, reset_i;
   logic        spi_sck_i, spi_di_i, spi_ss2_i, spi_ss3_i, conf_data0_i;
   logic [3:0]  game_r_i, game_g_i, game_b_i;
   logic        lhbl_i, lvbl_i, hs_i, vs_i;
   logic [5:0]  vga_r_i, vga_g_i, vga_b_i;
   logic        vga_hsync_i, vga_vsync_i;
   logic [15:0] snd_i;
   logic [5:0]  video_r_o, video_g_o, video_b_o;
   logic        video_hs_o, video_vs_o, osd_shown_o;
   logic [31:0] status_o, joystick1_o, joystick2_o;
   logic [21:0] ioctl_addr_o;
   logic [7:0]  ioctl_data_o;
   logic        ioctl_wr_o, downloading_o, snd_pwm_o;

   logic [15:0] lfsr;
   logic [7:0]  dl_expect[$];
   int          wr_count;

   mist_base mist_base_inst (.*);

   always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

   // x^16 + x^14 + x^13 + x^11, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic check_val(input string name, input logic [31:0] act,
                            input logic [31:0] expected);
      if (act !== expected) begin
         $display("** Error: %s = 0x%h, expected 0x%h", name, act, expected);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   // chip select 0 is conf_data0, 1 is ss2, 2 is ss3
   task automatic spi_select(input int cs, input logic level);
      case (cs)
         0: conf_data0_i = level;
         1: spi_ss2_i = level;
         default: spi_ss3_i = level;
      endcase
      repeat (8) @(negedge clk_sys);
   endtask

   // mode 0, MSB first
   task automatic spi_send(input logic [7:0] b);
      for (int i = 7; i >= 0; i--) begin
         spi_di_i  = b[i];
         spi_sck_i = 1'b0;
         repeat (PHASE) @(negedge clk_sys);
         spi_sck_i = 1'b1;
         repeat (PHASE) @(negedge clk_sys);
      end
      spi_sck_i = 1'b0;
   endtask

   task automatic send_cmd(input int cs, input logic [7:0] cmd);
      spi_select(cs, 1'b0);
      spi_send(cmd);
      spi_select(cs, 1'b1);
   endtask

   // command, word MSB first, optional surplus byte
   task automatic send_word(input logic [7:0] cmd, input logic [31:0] w, input logic extra);
      spi_select(0, 1'b0);
      spi_send(cmd);
      for (int i = 3; i >= 0; i--)
         spi_send(w[8*i +: 8]);
      if (extra)
         spi_send(8'(rand_bits(8)));
      spi_select(0, 1'b1);
   endtask

   // source mux and window tint, packed as {r, g, b, hs, vs}
   function automatic logic [19:0] overlay_model(input logic sd, input logic shown,
                                                 input int h, input int v);
      logic [5:0] r, g, b;
      logic       hs, vs;
      if (sd) begin
         r  = {game_r_i, game_r_i[3:2]};
         g  = {game_g_i, game_g_i[3:2]};
         b  = {game_b_i, game_b_i[3:2]};
         hs = ~hs_i;
         vs = ~vs_i;
      end else begin
         r  = vga_r_i;
         g  = vga_g_i;
         b  = vga_b_i;
         hs = vga_hsync_i;
         vs = vga_vsync_i;
      end
      if (shown && h >= WIN_X0 && h < WIN_X0 + WIN_W && v >= WIN_Y0 && v < WIN_Y0 + WIN_H) begin
         r = r >> 1;
         g = g >> 1;
         b = (b >> 1) | 6'h20;
      end
      return {r, g, b, hs, vs};
   endfunction

   function automatic int clamp_color(input int c);
      if (c < 0)
         return 0;
      else if (c > 63)
         return 63;
      return c;
   endfunction

   function automatic logic [19:0] convert_model(input logic [19:0] pix, input logic sd,
                                                 input logic yp);
      int   r, g, b, y, pb, pr;
      logic hs, vs;
      r  = pix[19:14];
      g  = pix[13:8];
      b  = pix[7:2];
      y  = (19 * r + 38 * g + 7 * b) / 64;
      pb = clamp_color(32 + (b - y) / 2);
      pr = clamp_color(32 + (r - y) / 2);
      hs = pix[1];
      vs = pix[0];
      if (sd || yp) begin
         hs = ~(pix[1] ^ pix[0]);
         vs = 1'b1;
      end
      if (yp)
         return {6'(pr), 6'(y), 6'(pb), hs, vs};
      return {pix[19:2], hs, vs};
   endfunction

   // one frame of random pixels, outputs checked two cycles after their inputs
   task automatic run_video(input logic sd, input logic yp, input logic shown);
      logic [19:0] exp1, exp2;
      int          h, v;
      logic        lhbl_d;
      exp1   = '0;
      exp2   = '0;
      h      = 0;
      v      = 0;
      lhbl_d = 1'b0;
      for (int k = 0; k < VID_LEN + 2; k++) begin
         if (k >= 2) begin
            check_val("video_r_o", video_r_o, exp2[19:14]);
            check_val("video_g_o", video_g_o, exp2[13:8]);
            check_val("video_b_o", video_b_o, exp2[7:2]);
            check_val("video_hs_o", video_hs_o, exp2[1]);
            check_val("video_vs_o", video_vs_o, exp2[0]);
         end
         exp2 = exp1;
         if (k < VID_LEN) begin
            lhbl_i      = (k % LINE_LEN) < LINE_ACT;
            lvbl_i      = (k / LINE_LEN) < FRAME_ACT;
            game_r_i    = 4'(rand_bits(4));
            game_g_i    = 4'(rand_bits(4));
            game_b_i    = 4'(rand_bits(4));
            vga_r_i     = 6'(rand_bits(6));
            vga_g_i     = 6'(rand_bits(6));
            vga_b_i     = 6'(rand_bits(6));
            hs_i        = 1'(rand_bits(1));
            vs_i        = 1'(rand_bits(1));
            vga_hsync_i = 1'(rand_bits(1));
            vga_vsync_i = 1'(rand_bits(1));
         end else begin
            lhbl_i = 1'b0;
            lvbl_i = 1'b0;
         end
         exp1 = convert_model(overlay_model(sd, shown, h, v), sd, yp);
         // beam position after this clock
         if (!lvbl_i)
            v = 0;
         else if (lhbl_d && !lhbl_i)
            v++;
         h      = lhbl_i ? h + 1 : 0;
         lhbl_d = lhbl_i;
         @(negedge clk_sys);
      end
   endtask

   // every write must match the next byte sent
   always @(negedge clk_sys) begin
      if (ioctl_wr_o) begin
         if (dl_expect.size() == 0) begin
            $display("an ioctl write appeared with no data byte sent for it");
            $display("TEST FAILED");
            $fatal(1);
         end
         check_val("ioctl_addr_o", ioctl_addr_o, wr_count);
         check_val("ioctl_data_o", ioctl_data_o, dl_expect.pop_front());
         wr_count++;
      end
   end

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("timeout: the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
   end

   initial begin
      logic [31:0] w_status, w_joy1, w_joy2, w;
      logic [7:0]  b;
      int          ones, expect_ones;
      lfsr     = 16'd11;
      wr_count = 0;
      clk_sys  = 1'b0;
      reset_i  = 1'b1;
      {spi_sck_i, spi_di_i} = 2'b00;
      {spi_ss2_i, spi_ss3_i, conf_data0_i} = 3'b111;
      {game_r_i, game_g_i, game_b_i} = '0;
      {vga_r_i, vga_g_i, vga_b_i} = '0;
      {lhbl_i, lvbl_i, hs_i, vs_i, vga_hsync_i, vga_vsync_i} = '0;
      snd_i = '0;
      repeat (2) @(negedge clk_sys);
      reset_i = 1'b0;

      check_val("ioctl_wr_o", ioctl_wr_o, 0);
      check_val("downloading_o", downloading_o, 0);
      check_val("osd_shown_o", osd_shown_o, 0);
      check_val("status_o", status_o, 0);
      check_val("joystick1_o", joystick1_o, 0);
      check_val("joystick2_o", joystick2_o, 0);
      check_val("snd_pwm_o", snd_pwm_o, 0);

      // user words, joysticks carry a surplus fifth byte
      w_status = rand_bits(32);
      w_joy1   = rand_bits(32);
      w_joy2   = rand_bits(32);
      send_word(OP_STATUS, w_status, 1'b0);
      send_word(OP_JOY1, w_joy1, 1'b1);
      send_word(OP_JOY2, w_joy2, 1'b1);
      check_val("status_o", status_o, w_status);
      check_val("joystick1_o", joystick1_o, w_joy1);
      check_val("joystick2_o", joystick2_o, w_joy2);

      send_cmd(1, OP_DL_START);
      check_val("downloading_o", downloading_o, 1);
      spi_select(1, 1'b0);
      spi_send(OP_DL_DATA);
      for (int i = 0; i < DL_N; i++) begin
         b = 8'(rand_bits(8));
         dl_expect.push_back(b);
         spi_send(b);
      end
      spi_select(1, 1'b1);
      check_val("downloading_o", downloading_o, 1);
      send_cmd(1, OP_DL_END);
      check_val("downloading_o", downloading_o, 0);
      check_val("ioctl write count", wr_count, DL_N);

      // bit 0 OSD shown, bit 1 native video, bit 2 YPbPr
      for (int m = 0; m < 8; m++) begin
         w             = rand_bits(32);
         w[BIT_SD_DIS] = m[1];
         w[BIT_YPBPR]  = m[2];
         send_word(OP_STATUS, w, 1'b0);
         check_val("status_o", status_o, w);
         send_cmd(2, m[0] ? OP_OSD_ON : OP_OSD_OFF);
         check_val("osd_shown_o", osd_shown_o, m[0]);
         run_video(m[1], m[2], m[0]);
      end

      for (int s = 0; s < SND_RUNS; s++) begin
         snd_i       = {8'(rand_bits(8)), 8'h00};
         expect_ones = (snd_i ^ 16'h8000) >> 8;
         repeat (2) @(negedge clk_sys);
         for (int win = 0; win < 2; win++) begin
            ones = 0;
            repeat (256) begin
               ones += snd_pwm_o;
               @(negedge clk_sys);
            end
            check_val("snd_pwm_o ones", ones, expect_ones);
         end
      end

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire
